// ==== tb.f ====
rf_pkg.sv
register_file.sv
alu.sv
operand_bypass.sv
exec_stage.sv
exec_core.sv
tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_exec_core -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb_exec_core.sv ====
// Self-checking testbench for the integer execute core
// Reference register model and ALU checked against the result strobe
`timescale 1ns/10ps

module tb_exec_core;

  import rf_pkg::*;

  // Cycles to wait for an outstanding result strobe
  localparam int RESULT_TIMEOUT = 8;
  localparam int DRAIN_TIMEOUT  = 16;
  localparam int RANDOM_CYCLES  = 600;

  // One expected result strobe and the cycle it is due in
  typedef struct packed {
    int       due;
    rf_addr_t rd;
    rf_data_t data;
  } expect_t;

  // DUT connections
  logic     clk;
  logic     rst_n;
  logic     instr_valid_i;
  instr_t   instr_i;
  wr_req_t  ext_wr_i;
  logic     result_valid_o;
  rf_addr_t result_rd_o;
  rf_data_t result_o;

  // Reference register model and the write-back still in flight
  rf_data_t model [REGFILE_NUM_WORDS];
  logic     pend_valid;
  rf_addr_t pend_rd;
  rf_data_t pend_data;
  expect_t  expect_q [$];

  // Rising edges seen so far
  int       cycle_cnt;

  exec_core dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .ext_wr_i       (ext_wr_i),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic rf_data_t alu_ref(input alu_op_e op, input rf_data_t a, input rf_data_t b);
    rf_data_t r;
    case (op)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a - b;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_SLL: r = a << b[4:0];
      ALU_SRL: r = a >> b[4:0];
      ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    return r;
  endfunction

  // Operand as seen this cycle with the external write ahead of write-back
  function automatic rf_data_t operand_ref(input rf_addr_t rs, input wr_req_t ext);
    rf_data_t v;
    if (rs == '0) begin
      v = '0;
    end else if (ext.we && (ext.waddr == rs)) begin
      v = ext.wdata;
    end else if (pend_valid && (pend_rd == rs)) begin
      v = pend_data;
    end else begin
      v = model[rs];
    end
    return v;
  endfunction

  function automatic instr_t make_instr(input alu_op_e op, input int rd, input int rs1,
                                        input int rs2);
    instr_t ins;
    ins.op  = op;
    ins.rd  = rf_addr_t'(rd);
    ins.rs1 = rf_addr_t'(rs1);
    ins.rs2 = rf_addr_t'(rs2);
    return ins;
  endfunction

  function automatic wr_req_t make_wr(input logic we, input int addr, input rf_data_t data);
    wr_req_t w;
    w.we    = we;
    w.waddr = rf_addr_t'(addr);
    w.wdata = data;
    return w;
  endfunction

  // Mostly plain random words with corner values now and then
  function automatic rf_data_t rand_word();
    case ($urandom_range(0, 7))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      default: return $urandom();
    endcase
  endfunction

  // Half the time from a small window so addresses collide often
  function automatic int rand_addr();
    if ($urandom_range(0, 1) == 0) begin
      return $urandom_range(0, 7);
    end
    return $urandom_range(0, 31);
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus tasks that each take one clock cycle
  // --------------------------------------------------------------------------

  task automatic drive_cycle(input logic iv, input instr_t ins, input wr_req_t ext);
    expect_t e;
    e = '0;
    @(posedge clk);
    #1;
    instr_valid_i = iv;
    instr_i       = ins;
    ext_wr_i      = ext;
    if (iv) begin
      e.due  = cycle_cnt + 1;
      e.rd   = ins.rd;
      e.data = alu_ref(ins.op, operand_ref(ins.rs1, ext), operand_ref(ins.rs2, ext));
      expect_q.push_back(e);
    end
    // Writes landing at the end of this cycle with the external one last so it wins
    if (pend_valid && (pend_rd != '0)) begin
      model[pend_rd] = pend_data;
    end
    if (ext.we && (ext.waddr != '0)) begin
      model[ext.waddr] = ext.wdata;
    end
    pend_valid = iv;
    pend_rd    = ins.rd;
    pend_data  = e.data;
  endtask

  task automatic issue(input alu_op_e op, input int rd, input int rs1, input int rs2);
    drive_cycle(1'b1, make_instr(op, rd, rs1, rs2), '0);
  endtask

  task automatic ext_write(input int addr, input rf_data_t data);
    drive_cycle(1'b0, '0, make_wr(1'b1, addr, data));
  endtask

  task automatic idle();
    drive_cycle(1'b0, '0, '0);
  endtask

  // --------------------------------------------------------------------------
  // Result checker
  // --------------------------------------------------------------------------

  initial begin : compare_results
    expect_t want;
    int      idle_cycles;
    idle_cycles = 0;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid_o) begin
        if (expect_q.size() == 0) begin
          abort_run("Result strobe seen with no instruction outstanding");
        end else begin
          want = expect_q.pop_front();
          assert (cycle_cnt == want.due) else begin
            abort_run($sformatf("error: %0t ns: result for rd %0d in cycle %0d, expected %0d",
                                $time, want.rd, cycle_cnt, want.due));
          end
          assert (result_rd_o == want.rd) else begin
            abort_run($sformatf("error: %0t ns: result_rd_o = %0d, expected %0d",
                                $time, result_rd_o, want.rd));
          end
          assert (result_o == want.data) else begin
            abort_run($sformatf("error: %0t ns: result_o = %h for rd %0d, expected %h",
                                $time, result_o, want.rd, want.data));
          end
          idle_cycles = 0;
        end
      end else if (expect_q.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > RESULT_TIMEOUT) begin
          abort_run("Timeout: an issued instruction produced no result strobe");
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin : stimulus
    int      prev_rd;
    int      rd;
    int      wait_cycles;
    logic    iv;
    wr_req_t ext;
    rf_data_t v;
    void'($urandom(32'h3ff9_dbb9));
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ext_wr_i      = '0;
    pend_valid    = 1'b0;
    pend_rd       = '0;
    pend_data     = '0;
    cycle_cnt     = 0;
    for (int r = 0; r < REGFILE_NUM_WORDS; r++) begin
      model[r] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Every register reads zero out of reset
    for (int r = 0; r < REGFILE_NUM_WORDS; r++) begin
      issue(ALU_OR, 0, r, 0);
    end

    // All opcodes on operands loaded through the external port
    for (int op = 0; op < 8; op++) begin
      for (int i = 0; i < 4; i++) begin
        ext_write(1, rand_word());
        ext_write(2, rand_word());
        issue(alu_op_e'(3'(op)), 3, 1, 2);
      end
    end

    // Dependent chain where each instruction reads the previous destination
    prev_rd = 3;
    for (int i = 0; i < 48; i++) begin
      rd = $urandom_range(1, 31);
      issue(alu_op_e'(3'($urandom_range(0, 7))), rd, prev_rd, $urandom_range(0, 31));
      prev_rd = rd;
    end

    // x0 ignores ALU and external writes while the result still shows the value
    drive_cycle(1'b1, make_instr(ALU_ADD, 0, 1, 2), make_wr(1'b1, 0, 32'hdead_beef));
    issue(ALU_OR, 8, 0, 0);
    ext_write(0, rand_word());
    issue(ALU_ADD, 9, 0, 0);
    issue(ALU_XOR, 0, 9, 3);
    issue(ALU_SUB, 10, 0, 0);

    // External data survives a collision on r5
    v = rand_word();
    issue(ALU_ADD, 5, 1, 2);
    drive_cycle(1'b1, make_instr(ALU_OR, 6, 5, 0), make_wr(1'b1, 5, v));
    idle();
    issue(ALU_OR, 7, 5, 0);

    // Long random mix
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      iv  = ($urandom_range(0, 3) != 0);
      ext = make_wr(($urandom_range(0, 2) == 0), rand_addr(), rand_word());
      drive_cycle(iv, make_instr(alu_op_e'(3'($urandom_range(0, 7))), rand_addr(),
                                 rand_addr(), rand_addr()), ext);
    end

    // Let the last results drain
    wait_cycles = 0;
    while ((expect_q.size() != 0) && (wait_cycles < DRAIN_TIMEOUT)) begin
      idle();
      wait_cycles++;
    end
    idle();

    if (expect_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run("Results outstanding or missing at the end of the run");
    end
  end

endmodule

// ==== exec_core.sv ====
// Integer execute core top level
// Register file, operand bypass and execute stage, one issue per cycle
`timescale 1ns/10ps

module exec_core (
  // Clock and reset
  input  logic             clk,
  input  logic             rst_n,

  // Instruction issue strobe
  input  logic             instr_valid_i,
  input  rf_pkg::instr_t   instr_i,

  // External write path, e.g. returning load data
  input  rf_pkg::wr_req_t  ext_wr_i,

  // Result strobe
  output logic             result_valid_o,
  output rf_pkg::rf_addr_t result_rd_o,
  output rf_pkg::rf_data_t result_o
);

  import rf_pkg::*;

  // Read side
  rf_addr_t raddr    [REGFILE_NUM_READ_PORTS];
  rf_data_t rf_rdata [REGFILE_NUM_READ_PORTS];
  rf_data_t operand  [REGFILE_NUM_READ_PORTS];

  // Write side
  wr_req_t  wb_req;
  wr_req_t  wr_req   [REGFILE_NUM_WRITE_PORTS];

  // --------------------------------------------------------------------------
  // Port arrays
  // --------------------------------------------------------------------------

  assign raddr[OPA_PORT] = instr_i.rs1;
  assign raddr[OPB_PORT] = instr_i.rs2;

  // External port sits above write-back in priority
  assign wr_req[WB_PORT]  = wb_req;
  assign wr_req[EXT_PORT] = ext_wr_i;

  // --------------------------------------------------------------------------
  // Instances
  // --------------------------------------------------------------------------

  register_file register_file_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (raddr),
    .rdata_o (rf_rdata),
    .wr_i    (wr_req)
  );

  operand_bypass operand_bypass_i (
    .raddr_i    (raddr),
    .rf_rdata_i (rf_rdata),
    .wr_i       (wr_req),
    .operand_o  (operand)
  );

  exec_stage exec_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .operand_i      (operand),
    .wb_o           (wb_req),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o)
  );

endmodule

// ==== exec_stage.sv ====
// Execute stage with one pipeline register after the ALU
// Drives write-back on port 0 and the result outputs one cycle after issue
`timescale 1ns/10ps

module exec_stage (
  // Clock and reset
  input  logic             clk,
  input  logic             rst_n,

  // Issue
  input  logic             instr_valid_i,
  input  rf_pkg::instr_t   instr_i,
  input  rf_pkg::rf_data_t operand_i [rf_pkg::REGFILE_NUM_READ_PORTS],

  // Write-back request on register file port 0
  output rf_pkg::wr_req_t  wb_o,

  // Result outputs
  output logic             result_valid_o,
  output rf_pkg::rf_addr_t result_rd_o,
  output rf_pkg::rf_data_t result_o
);

  import rf_pkg::*;

  // ALU output in cycle N
  rf_data_t alu_result;

  // Pipeline register read out in cycle N+1
  logic     valid_q;
  rf_addr_t rd_q;
  rf_data_t result_q;

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------

  alu alu_i (
    .op_i     (instr_i.op),
    .a_i      (operand_i[OPA_PORT]),
    .b_i      (operand_i[OPB_PORT]),
    .result_o (alu_result)
  );

  // --------------------------------------------------------------------------
  // Pipeline register
  // --------------------------------------------------------------------------

  // Valid bit is a one-cycle strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;
    end
  end

  // Payload only loads on issue
  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      rd_q     <= instr_i.rd;
      result_q <= alu_result;
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------

  // The register file drops a write-back to x0
  assign wb_o.we    = valid_q;
  assign wb_o.waddr = rd_q;
  assign wb_o.wdata = result_q;

  // Core outputs carry the same data even for rd = 0
  assign result_valid_o = valid_q;
  assign result_rd_o    = rd_q;
  assign result_o       = result_q;

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // Write-back follows issue by exactly one cycle
  a_wb_timing: assert property (@(posedge clk) disable iff (!rst_n)
    1'b1 |=> (wb_o.we == $past(instr_valid_i)));

endmodule

// ==== operand_bypass.sv ====
// Operand bypass for same-cycle register writes
// Forwards write-port data to matching read ports, external port first
`timescale 1ns/10ps

module operand_bypass (
  input  rf_pkg::rf_addr_t raddr_i    [rf_pkg::REGFILE_NUM_READ_PORTS],
  input  rf_pkg::rf_data_t rf_rdata_i [rf_pkg::REGFILE_NUM_READ_PORTS],
  input  rf_pkg::wr_req_t  wr_i       [rf_pkg::REGFILE_NUM_WRITE_PORTS],
  output rf_pkg::rf_data_t operand_o  [rf_pkg::REGFILE_NUM_READ_PORTS]
);

  import rf_pkg::*;

  // --------------------------------------------------------------------------
  // Forwarding mux
  // --------------------------------------------------------------------------

  always_comb begin
    for (int rp = 0; rp < REGFILE_NUM_READ_PORTS; rp++) begin
      // Default to register file data
      operand_o[rp] = rf_rdata_i[rp];

      // x0 is never forwarded
      if (raddr_i[rp] != '0) begin
        // Scan low to high so the highest port wins, as in the register file
        for (int wp = 0; wp < REGFILE_NUM_WRITE_PORTS; wp++) begin
          if (wr_i[wp].we && (wr_i[wp].waddr == raddr_i[rp])) begin
            operand_o[rp] = wr_i[wp].wdata;
          end
        end
      end
    end
  end

endmodule

// ==== alu.sv ====
// Combinational integer ALU
// Add, sub, logic ops, logical shifts and signed set-less-than
`timescale 1ns/10ps

module alu (
  input  rf_pkg::alu_op_e  op_i,
  input  rf_pkg::rf_data_t a_i,
  input  rf_pkg::rf_data_t b_i,
  output rf_pkg::rf_data_t result_o
);

  import rf_pkg::*;

  // Shift amount from low bits of b
  logic [ALU_SHAMT_WIDTH-1:0] shamt;

  // Signed compare result
  logic lt_signed;

  assign shamt     = b_i[ALU_SHAMT_WIDTH-1:0];
  assign lt_signed = $signed(a_i) < $signed(b_i);

  // --------------------------------------------------------------------------
  // Operation select
  // --------------------------------------------------------------------------

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      // Logical shifts, zero fill
      ALU_SLL: result_o = a_i << shamt;
      ALU_SRL: result_o = a_i >> shamt;
      // Zero-extended compare flag
      ALU_SLT: result_o = {{(REGFILE_DATA_WIDTH-1){1'b0}}, lt_signed};
      default: result_o = '0;
    endcase
  end

endmodule

// ==== register_file.sv ====
// Flip-flop register file, 32 x 32 bit, x0 hard wired to zero
// Two combinational read ports, two write ports with highest-port priority
`timescale 1ns/10ps

module register_file (
  // Clock and reset
  input  logic             clk,
  input  logic             rst_n,

  // Read ports
  input  rf_pkg::rf_addr_t raddr_i [rf_pkg::REGFILE_NUM_READ_PORTS],
  output rf_pkg::rf_data_t rdata_o [rf_pkg::REGFILE_NUM_READ_PORTS],

  // Write ports
  input  rf_pkg::wr_req_t  wr_i    [rf_pkg::REGFILE_NUM_WRITE_PORTS]
);

  import rf_pkg::*;

  // Register storage
  rf_data_t mem [REGFILE_NUM_WORDS];

  // Per-port one-hot write enables, x0 has no enable
  logic [REGFILE_NUM_WORDS-1:1] we_dec [REGFILE_NUM_WRITE_PORTS];

  // --------------------------------------------------------------------------
  // Read decoder
  // --------------------------------------------------------------------------

  for (genvar rp = 0; rp < REGFILE_NUM_READ_PORTS; rp++) begin : gen_rdata
    assign rdata_o[rp] = mem[raddr_i[rp]];
  end

  // --------------------------------------------------------------------------
  // Write decoder
  // --------------------------------------------------------------------------

  for (genvar wp = 0; wp < REGFILE_NUM_WRITE_PORTS; wp++) begin : gen_we_port
    for (genvar r = 1; r < REGFILE_NUM_WORDS; r++) begin : gen_we_reg
      assign we_dec[wp][r] = wr_i[wp].we && (wr_i[wp].waddr == rf_addr_t'(r));
    end
  end

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // x0 is constant zero
  assign mem[0] = '0;

  for (genvar r = 1; r < REGFILE_NUM_WORDS; r++) begin : gen_rf
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[r] <= '0;
      end else begin
        // Later port overrides earlier one
        for (int p = 0; p < REGFILE_NUM_WRITE_PORTS; p++) begin
          if (we_dec[p][r]) begin
            mem[r] <= wr_i[p].wdata;
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // Any read of x0 returns zero, even right after a write aimed at x0
  for (genvar rp = 0; rp < REGFILE_NUM_READ_PORTS; rp++) begin : gen_chk_x0
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (raddr_i[rp] == '0) |-> (rdata_o[rp] == '0));
  end

  // Storage never goes unknown once out of reset
  for (genvar r = 0; r < REGFILE_NUM_WORDS; r++) begin : gen_chk_known
    a_no_x: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(mem[r]));
  end

  // Colliding writes leave the external port's data behind
  a_port_prio: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_i[WB_PORT].we && wr_i[EXT_PORT].we &&
     (wr_i[WB_PORT].waddr == wr_i[EXT_PORT].waddr) && (wr_i[EXT_PORT].waddr != '0))
    |=> (mem[$past(wr_i[EXT_PORT].waddr)] == $past(wr_i[EXT_PORT].wdata)));

endmodule

// ==== rf_pkg.sv ====
// Shared sizes, types and request structs for the integer execute core
// Register file geometry, ALU opcodes and write-port request format
package rf_pkg;

  // --------------------------------------------------------------------------
  // Register file geometry
  // --------------------------------------------------------------------------

  // Architectural registers, x0 included
  localparam int REGFILE_NUM_WORDS       = 32;
  localparam int REGFILE_NUM_READ_PORTS  = 2;
  localparam int REGFILE_NUM_WRITE_PORTS = 2;

  localparam int REGFILE_ADDR_WIDTH = $clog2(REGFILE_NUM_WORDS);
  localparam int REGFILE_DATA_WIDTH = 32;

  // Write port roles, higher index wins on a collision
  localparam int WB_PORT  = 0;
  localparam int EXT_PORT = 1;

  // Read port roles
  localparam int OPA_PORT = 0;
  localparam int OPB_PORT = 1;

  // Shift amount is taken from the low bits of operand b
  localparam int ALU_SHAMT_WIDTH = 5;

  // --------------------------------------------------------------------------
  // Basic types
  // --------------------------------------------------------------------------

  typedef logic [REGFILE_ADDR_WIDTH-1:0] rf_addr_t;
  typedef logic [REGFILE_DATA_WIDTH-1:0] rf_data_t;

  // ALU opcodes
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7   // signed less-than, yields 1 or 0
  } alu_op_e;

  // --------------------------------------------------------------------------
  // Request structs
  // --------------------------------------------------------------------------

  // Issued instruction, 18 bits
  typedef struct packed {
    alu_op_e  op;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
  } instr_t;

  // One write port request, 38 bits
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
  } wr_req_t;

endpackage
